// ==== ex_core.f ====
+incdir+logic
logic/ex_isa_pkg.sv
logic/ex_dp_pkg.sv
logic/ex_counters.sv
logic/ex_issue_fsm.sv
logic/ex_regfile.sv
logic/ex_alu.sv
logic/ex_pred.sv
logic/ex_core.sv
verif/ex_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := ex_tb
FILELIST  := ex_core.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
BUILD_DIR := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard logic/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message or the simulator exits badly.
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "Simulation run reported an error, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/ex_tb.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Self-checking testbench for the nibble-serial execution core. A model of
// the registers, P, the mask and the repeat counter predicts every
// write-back slice and every predicate value.
module ex_tb import ex_isa_pkg::*, ex_dp_pkg::*; ();

  localparam int CLK_HALF    = 4;
  localparam int N_LOAD_REGS = 14;
  localparam int N_ALU       = 48;
  localparam int N_R0        = 8;
  localparam int N_CMP       = 32;
  localparam int N_ROUNDS    = 6;

  // Upper bound on the words used. It covers set-up, the constant loads, all
  // tests and the two drain words after each of the six tests.
  localparam int MAX_INSTR = 3 + N_LOAD_REGS * 33 + N_ALU + N_R0 + N_CMP
                           + N_ROUNDS * (5 + 6 + 9) + 6 * 2;
  localparam int TIMEOUT_CYCLES = 4 * MAX_INSTR + 64;

  logic   gck;
  logic   rst_n;
  instr_t instr;
  logic   instr_vld;
  wb_t    wb;
  logic   pred;

  // Reference model state.
  logic [`EX_DATA_W-1:0] m_regs [`EX_NUM_REGS];
  logic                  m_pred;
  logic [`EX_COND_W-1:0] m_mask;
  logic [`EX_CNT_W-1:0]  m_count;
  count_mode_e           m_mode;
  logic                  m_first;
  logic                  m_carry;

  // The instruction sampled at the end of the last word, and the slices
  // expected from it in the current word.
  instr_t pend_instr;
  logic   pend_vld;
  wb_t    exp_wb [`EX_NUM_SLICES];

  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          tests_done;
  int          checks;
  int          errors;
  int          test_errs;

  ex_core u_dut (
    .i_ex_gck       (gck),
    .i_ex_rst_n     (rst_n),
    .i_ex_instr     (instr),
    .i_ex_instr_vld (instr_vld),
    .o_ex_wb        (wb),
    .o_ex_pred      (pred)
  );

  always #(CLK_HALF) gck = ~gck;

  // Guard against a run that never reaches its end.
  always @(posedge gck) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // Linear congruential generator. The upper half has the better bits.
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic int rand_below(input int n);
    return int'(lcg_next()) % n;
  endfunction

  function automatic reg_t rand_reg();
    return reg_t'(rand_below(`EX_NUM_REGS));
  endfunction

  // Destinations avoid r0 and r1, since r1 holds the constant one.
  function automatic reg_t rand_dst();
    return reg_t'(2 + rand_below(`EX_NUM_REGS - 2));
  endfunction

  // ALU ops are the five encodings from OP_ADD, compares the three from OP_CEQ.
  function automatic opcode_e rand_alu_op();
    return opcode_e'(4'(int'(OP_ADD) + rand_below(5)));
  endfunction

  function automatic opcode_e rand_cmp_op();
    return opcode_e'(4'(int'(OP_CEQ) + rand_below(3)));
  endfunction

  function automatic instr_t make_instr(input opcode_e op, input reg_t dst,
                                        input reg_t lhs, input reg_t rhs);
    instr_t ins;
    ins.op  = op;
    ins.dst = dst;
    ins.lhs = lhs;
    ins.rhs = rhs;
    return ins;
  endfunction

  task automatic check_wb(input wb_t got, input wb_t exp, input string what);
    logic bad;
    checks++;
    bad = got.vld !== exp.vld || got.idx !== exp.idx;
    if (exp.vld) begin
      bad = bad || got.dst !== exp.dst || got.data !== exp.data;
    end
    if (bad) begin
      errors++;
      test_errs++;
      $display("CHECK FAILED at %0t: %s, got vld=%b dst=%0d idx=%0d data=%h,", $time, what,
               got.vld, got.dst, got.idx, got.data);
      $display("  expected vld=%b dst=%0d idx=%0d data=%h", exp.vld, exp.dst, exp.idx,
               exp.data);
    end
  endtask

  task automatic check_pred(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("CHECK FAILED at %0t: %s, got P=%b, expected P=%b", $time, what, got, exp);
    end
  endtask

  // Runs one instruction through the model. Skipped instructions still use up
  // a mask bit and a count, but write nothing.
  task automatic model_exec(input instr_t ins, input logic vld);
    logic                  skip;
    logic                  chain;
    logic                  cin;
    logic                  res;
    logic                  ovf;
    logic [`EX_DATA_W-1:0] a;
    logic [`EX_DATA_W-1:0] b;
    logic [`EX_DATA_W:0]   sum;
    logic [`EX_DATA_W-1:0] result;
    for (int k = 0; k < `EX_NUM_SLICES; k++) begin
      exp_wb[k]     = '0;
      exp_wb[k].idx = slice_idx_t'(k);
    end
    if (!vld) begin
      return;
    end
    skip   = m_mask[`EX_COND_W-1:1] != '0 && m_pred != m_mask[0];
    chain  = m_mode == CNT_CARRY && m_count != '0 && !m_first;
    a      = (ins.lhs == '0) ? '0 : m_regs[ins.lhs];
    b      = (ins.rhs == '0) ? '0 : m_regs[ins.rhs];
    result = '0;
    sum    = '0;
    case (ins.op)
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_ADD, OP_SUB, OP_CEQ, OP_CLT, OP_CLTU: begin
        // Everything but ADD subtracts, as a + ~b + 1 unless chained.
        if (ins.op != OP_ADD) begin
          b = ~b;
        end
        cin    = chain ? m_carry : ins.op != OP_ADD;
        sum    = {1'b0, a} + {1'b0, b} + {{`EX_DATA_W{1'b0}}, cin};
        result = sum[`EX_DATA_W-1:0];
        if (!skip) begin
          m_carry = sum[`EX_DATA_W];
        end
      end
      default: result = '0;
    endcase
    if (!skip && ins.op inside {OP_CEQ, OP_CLT, OP_CLTU}) begin
      ovf = a[`EX_DATA_W-1] == b[`EX_DATA_W-1] && result[`EX_DATA_W-1] != a[`EX_DATA_W-1];
      case (ins.op)
        OP_CEQ:  res = result == '0;
        OP_CLT:  res = result[`EX_DATA_W-1] != ovf;
        default: res = !sum[`EX_DATA_W];
      endcase
      // An active ANDP or ORP count folds the result into the old P.
      if (m_count != '0 && m_mode == CNT_ANDP) begin
        res = res & m_pred;
      end else if (m_count != '0 && m_mode == CNT_ORP) begin
        res = res | m_pred;
      end
      m_pred = res;
    end
    if (!skip && ins.dst != '0 && ins.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR}) begin
      m_regs[ins.dst] = result;
      for (int k = 0; k < `EX_NUM_SLICES; k++) begin
        exp_wb[k].vld  = 1'b1;
        exp_wb[k].dst  = ins.dst;
        exp_wb[k].data = result[k*`EX_SLICE_W +: `EX_SLICE_W];
      end
    end
    if (!skip && ins.op == OP_COND) begin
      m_mask = {ins.lhs, ins.rhs};
    end else begin
      m_mask = m_mask >> 1;
    end
    if (!skip && ins.op == OP_CNT) begin
      m_count = ins.rhs;
      m_mode  = count_mode_e'(ins.lhs[1:0]);
      m_first = 1'b1;
    end else begin
      m_first = 1'b0;
      if (m_count != '0) begin
        m_count = m_count - 4'd1;
      end
    end
  endtask

  // One word period, entered 1 ns after the edge that starts slice 0. The
  // instruction sampled last word executes now, and the next one is offered
  // in slice 3. Outputs are sampled at the falling edge.
  task automatic run_word(input instr_t nxt, input logic nxt_vld);
    logic p_before;
    p_before = m_pred;
    model_exec(pend_instr, pend_vld);
    for (int k = 0; k < `EX_NUM_SLICES; k++) begin
      if (k == `EX_NUM_SLICES - 1) begin
        instr     = nxt;
        instr_vld = nxt_vld;
      end
      @(negedge gck);
      if (k == 0) begin
        check_pred(pred, p_before, "P after previous instruction");
      end
      check_wb(wb, exp_wb[k], "write-back slice");
      @(posedge gck);
      #1;
    end
    pend_instr = nxt;
    pend_vld   = nxt_vld;
  endtask

  task automatic issue(input opcode_e op, input reg_t dst, input reg_t lhs, input reg_t rhs);
    run_word(make_instr(op, dst, lhs, rhs), 1'b1);
  endtask

  // Two idle words let the last instruction's slices and P be checked.
  task automatic finish_test(input string name);
    run_word('0, 1'b0);
    run_word('0, 1'b0);
    tests_done++;
    $display("test %0d %s: %s with %0d errors", tests_done, name,
             (test_errs == 0) ? "done" : "FAILED", test_errs);
    test_errs = 0;
  endtask

  // Builds a constant by shift-and-add from r1, which holds one.
  task automatic load_const(input reg_t dst, input logic [15:0] value);
    issue(OP_AND, dst, 4'd0, 4'd0);
    for (int i = `EX_DATA_W - 1; i >= 0; i--) begin
      issue(OP_ADD, dst, dst, dst);
      if (value[i]) begin
        issue(OP_ADD, dst, dst, 4'd1);
      end
    end
  endtask

  task automatic rand_cmp();
    reg_t lhs;
    lhs = rand_reg();
    // Equal operands now and then so that CEQ also comes out true.
    if (rand_below(4) == 0) begin
      issue(rand_cmp_op(), rand_reg(), lhs, lhs);
    end else begin
      issue(rand_cmp_op(), rand_reg(), lhs, rand_reg());
    end
  endtask

  initial begin
    int            n;
    opcode_e       op;
    logic [7:0]    mask;
    logic [15:0]   rnd;
    gck        = 1'b0;
    rst_n      = 1'b0;
    instr      = '0;
    instr_vld  = 1'b0;
    lcg_state  = 32'd19363;
    cycle_cnt  = 0;
    tests_done = 0;
    checks     = 0;
    errors     = 0;
    test_errs  = 0;
    for (int i = 0; i < `EX_NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
    m_pred     = 1'b0;
    m_mask     = '0;
    m_count    = '0;
    m_mode     = CNT_NONE;
    m_first    = 1'b0;
    m_carry    = 1'b0;
    pend_instr = '0;
    pend_vld   = 1'b0;
    repeat (3) @(posedge gck);
    #1;
    rst_n = 1'b1;

    // A two-step carry chain makes r1 = 0 + 0 + carry of (0 - 0) = 1.
    issue(OP_CNT, 4'd0, reg_t'(CNT_CARRY), 4'd2);
    issue(OP_SUB, 4'd1, 4'd0, 4'd0);
    issue(OP_ADD, 4'd1, 4'd0, 4'd0);
    for (int r = 2; r < 2 + N_LOAD_REGS; r++) begin
      load_const(reg_t'(r), lcg_next());
    end
    for (int i = 0; i < N_ALU; i++) begin
      issue(rand_alu_op(), rand_dst(), rand_reg(), rand_reg());
    end
    finish_test("alu random");

    issue(OP_ADD, 4'd0, 4'd2, 4'd3);
    issue(OP_XOR, 4'd0, 4'd4, 4'd5);
    issue(OP_OR, 4'd7, 4'd0, 4'd0);
    issue(OP_ADD, 4'd8, 4'd0, 4'd6);
    issue(OP_SUB, 4'd9, 4'd6, 4'd0);
    issue(OP_SUB, 4'd10, 4'd0, 4'd6);
    issue(OP_AND, 4'd11, 4'd0, 4'd5);
    issue(OP_CEQ, 4'd0, 4'd0, 4'd0);
    finish_test("zero register");

    for (int i = 0; i < N_CMP; i++) begin
      rand_cmp();
    end
    finish_test("compare random");

    // Word w of a multi-word operand lives in r(2+w) and r(6+w).
    for (int r = 0; r < N_ROUNDS; r++) begin
      n  = 1 + rand_below(3);
      op = (rand_below(2) == 0) ? OP_ADD : OP_SUB;
      issue(OP_CNT, 4'd0, reg_t'(CNT_CARRY), reg_t'(n));
      for (int w = 0; w <= n; w++) begin
        issue(op, reg_t'(10 + w), reg_t'(2 + w), reg_t'(6 + w));
      end
    end
    finish_test("carry chain");

    for (int r = 0; r < N_ROUNDS; r++) begin
      n = 2 + rand_below(3);
      rand_cmp();
      issue(OP_CNT, 4'd0, reg_t'((r % 2 == 0) ? CNT_ANDP : CNT_ORP), reg_t'(n));
      for (int i = 0; i < n; i++) begin
        rand_cmp();
      end
    end
    finish_test("predicate combine");

    // The COND itself uses one count, and skipped ops keep counting down.
    for (int r = 0; r < N_ROUNDS; r++) begin
      rnd  = lcg_next();
      mask = rnd[7:0];
      if (mask[7:1] == '0) begin
        mask[7] = 1'b1;
      end
      rand_cmp();
      issue(OP_CNT, 4'd0, reg_t'(CNT_ORP), 4'd4);
      issue(OP_COND, 4'd0, mask[7:4], mask[3:0]);
      for (int i = 0; i < 6; i++) begin
        if (rand_below(2) == 0) begin
          issue(rand_alu_op(), rand_dst(), rand_reg(), rand_reg());
        end else begin
          rand_cmp();
        end
      end
    end
    finish_test("conditional mask");

    $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== logic/ex_core.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Top of the nibble-serial execution core.
module ex_core import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // One instruction may be offered in every fourth cycle.
  input  var instr_t i_ex_instr,
  input  var logic   i_ex_instr_vld,

  output var wb_t    o_ex_wb,
  output var logic   o_ex_pred
);

  slice_idx_t           slice;
  alu_ctrl_t            ctrl;
  logic                 instr_done;
  logic                 cnt_load;
  count_mode_e          cnt_mode;
  logic [`EX_CNT_W-1:0] cnt_val;
  logic                 chain;
  count_mode_e          mode;
  slice_t               lhs_data;
  slice_t               rhs_data;
  slice_t               alu_out;
  flags_t               flags;
  logic                 pred;
  logic                 wb_vld;

  ex_counters u_counters (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_cnt_load   (cnt_load),
    .i_cnt_mode   (cnt_mode),
    .i_cnt_val    (cnt_val),
    .i_instr_done (instr_done),
    .o_slice      (slice),
    .o_chain      (chain),
    .o_mode       (mode)
  );

  ex_issue_fsm u_issue (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_slice      (slice),
    .i_instr      (i_ex_instr),
    .i_instr_vld  (i_ex_instr_vld),
    .i_pred       (pred),
    .o_ctrl       (ctrl),
    .o_instr_done (instr_done),
    .o_cnt_load   (cnt_load),
    .o_cnt_mode   (cnt_mode),
    .o_cnt_val    (cnt_val)
  );

  ex_regfile u_regfile (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_slice    (slice),
    .i_lhs      (ctrl.lhs),
    .i_rhs      (ctrl.rhs),
    .o_lhs_data (lhs_data),
    .o_rhs_data (rhs_data),
    .i_wr_en    (wb_vld),
    .i_wr_reg   (ctrl.dst),
    .i_wr_data  (alu_out)
  );

  ex_alu u_alu (
    .i_ex_gck (i_ex_gck),
    .i_slice  (slice),
    .i_ctrl   (ctrl),
    .i_chain  (chain),
    .i_lhs    (lhs_data),
    .i_rhs    (rhs_data),
    .o_out    (alu_out),
    .o_flags  (flags)
  );

  ex_pred u_pred (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_slice    (slice),
    .i_ctrl     (ctrl),
    .i_flags    (flags),
    .i_mode     (mode),
    .o_pred     (pred)
  );

  // Only register-writing ops produce write-back, and never to r0.
  always_comb wb_vld = ctrl.run && ctrl.dst != '0
                    && ctrl.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

  always_comb begin
    o_ex_wb.vld  = wb_vld;
    o_ex_wb.dst  = ctrl.dst;
    o_ex_wb.idx  = slice;
    o_ex_wb.data = alu_out;
  end

  always_comb o_ex_pred = pred;

endmodule

// ==== logic/ex_pred.sv ====
`timescale 1ns/100ps

// Predicate register. Compares write it on their final slice, optionally
// folded into the old value by an active ANDP or ORP count.
module ex_pred import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic        i_ex_gck,
  input  var logic        i_ex_rst_n,

  input  var slice_idx_t  i_slice,
  input  var alu_ctrl_t   i_ctrl,
  input  var flags_t      i_flags,
  input  var count_mode_e i_mode,

  output var logic        o_pred
);

  logic pred_q;
  logic cmp_res;
  logic pred_d;
  logic pred_wr;

  // Result of the compare from the top-slice flags.
  always_comb begin
    case (i_ctrl.op)
      OP_CEQ:  cmp_res = i_flags.z;
      OP_CLT:  cmp_res = i_flags.n != i_flags.v;
      OP_CLTU: cmp_res = !i_flags.c;
      default: cmp_res = pred_q;
    endcase
  end

  // Modes other than ANDP and ORP just replace P.
  always_comb begin
    unique case (i_mode)
      CNT_ANDP: pred_d = cmp_res & pred_q;
      CNT_ORP:  pred_d = cmp_res | pred_q;
      default:  pred_d = cmp_res;
    endcase
  end

  always_comb pred_wr = i_ctrl.run && &i_slice
                     && i_ctrl.op inside {OP_CEQ, OP_CLT, OP_CLTU};

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end else if (pred_wr) begin
      pred_q <= pred_d;
    end
  end

  always_comb o_pred = pred_q;

endmodule

// ==== logic/ex_alu.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Slice-serial ALU. Carries ripple between slices through a register and can
// also be handed on between instructions in a carry chain.
module ex_alu import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic       i_ex_gck,

  input  var slice_idx_t i_slice,
  input  var alu_ctrl_t  i_ctrl,
  input  var logic       i_chain,

  input  var slice_t     i_lhs,
  input  var slice_t     i_rhs,
  output var slice_t     o_out,
  output var flags_t     o_flags
);

  localparam int MSB = `EX_SLICE_W - 1;

  logic                 add_op;
  logic                 inv_rhs;
  logic                 cin;
  slice_t               rhs_eff;
  logic [`EX_SLICE_W:0] sum;
  logic                 carry_q;
  logic                 z_q;
  logic                 z_acc;

  // Subtract and all compares are lhs + ~rhs + 1.
  always_comb add_op  = i_ctrl.op inside {OP_ADD, OP_SUB, OP_CEQ, OP_CLT, OP_CLTU};
  always_comb inv_rhs = i_ctrl.op inside {OP_SUB, OP_CEQ, OP_CLT, OP_CLTU};

  // On slice 0 the carry-in is the op's default (1 when inverting) unless a
  // carry chain is active. Later slices always take the ripple carry.
  always_comb begin
    if (i_slice == '0) begin
      cin = i_chain ? carry_q : inv_rhs;
    end else begin
      cin = carry_q;
    end
  end

  always_comb rhs_eff = inv_rhs ? ~i_rhs : i_rhs;

  always_comb sum = {1'b0, i_lhs} + {1'b0, rhs_eff} + {{`EX_SLICE_W{1'b0}}, cin};

  always_comb begin
    unique case (i_ctrl.op)
      OP_AND:  o_out = i_lhs & i_rhs;
      OP_OR:   o_out = i_lhs | i_rhs;
      OP_XOR:  o_out = i_lhs ^ i_rhs;
      default: o_out = sum[MSB:0];
    endcase
  end

  // The carry is left alone by skipped and non-arithmetic instructions, so
  // after slice 3 it holds the carry-out of the last arithmetic op.
  always_ff @(posedge i_ex_gck) begin
    if (i_ctrl.run && add_op) begin
      carry_q <= sum[`EX_SLICE_W];
    end
  end

  // Zero flag builds up over the word and restarts at slice 0.
  always_comb z_acc = (~|i_slice || z_q) && ~|o_out;

  always_ff @(posedge i_ex_gck) begin
    z_q <= z_acc;
  end

  // Sign, carry and overflow only mean something on the top slice.
  always_comb begin
    o_flags.z = z_acc;
    o_flags.n = o_out[MSB];
    o_flags.c = sum[`EX_SLICE_W];
    o_flags.v = (i_lhs[MSB] == rhs_eff[MSB]) && (sum[MSB] != i_lhs[MSB]);
  end

endmodule

// ==== logic/ex_regfile.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Register file accessed one slice at a time. Two read ports and one write
// port all use the slice picked by the slice counter.
module ex_regfile import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic       i_ex_gck,
  input  var logic       i_ex_rst_n,

  input  var slice_idx_t i_slice,

  input  var reg_t       i_lhs,
  input  var reg_t       i_rhs,
  output var slice_t     o_lhs_data,
  output var slice_t     o_rhs_data,

  input  var logic       i_wr_en,
  input  var reg_t       i_wr_reg,
  input  var slice_t     i_wr_data
);

  logic [`EX_DATA_W-1:0] regs_q [`EX_NUM_REGS];

  // Reads see the old value in the cycle of a write, so an instruction
  // can safely use its destination as a source.
  always_comb begin
    o_lhs_data = regs_q[i_lhs][i_slice*`EX_SLICE_W +: `EX_SLICE_W];
    o_rhs_data = regs_q[i_rhs][i_slice*`EX_SLICE_W +: `EX_SLICE_W];
    // r0 is the zero register.
    if (i_lhs == '0) o_lhs_data = '0;
    if (i_rhs == '0) o_rhs_data = '0;
  end

  // One slice of the destination is written per cycle.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      for (int i = 0; i < `EX_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs_q[i_wr_reg][i_slice*`EX_SLICE_W +: `EX_SLICE_W] <= i_wr_data;
    end
  end

  // Write-back qualification upstream must filter out r0.
  a_no_r0_write: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    i_wr_en |-> i_wr_reg != '0
  );

endmodule

// ==== logic/ex_issue_fsm.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Issue sequencer. Latches one instruction per word period, decides whether
// it runs under the conditional mask and hands control to the datapath.
module ex_issue_fsm import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,

  input  var slice_idx_t           i_slice,
  input  var instr_t               i_instr,
  input  var logic                 i_instr_vld,
  input  var logic                 i_pred,

  output var alu_ctrl_t            o_ctrl,
  output var logic                 o_instr_done,

  // Repeat counter load for count instructions.
  output var logic                 o_cnt_load,
  output var count_mode_e          o_cnt_mode,
  output var logic [`EX_CNT_W-1:0] o_cnt_val
);

  issue_state_e          state_q;
  issue_state_e          state_d;
  instr_t                instr_q;
  logic [`EX_COND_W-1:0] mask_q;
  logic                  slice_last;
  logic                  skip;
  logic                  run;

  always_comb slice_last = &i_slice;

  // New instructions are only sampled at the edge that ends the last slice,
  // so execution of one overlaps the sampling of the next.
  always_comb begin
    state_d = state_q;
    if (slice_last) begin
      state_d = i_instr_vld ? ST_EXEC : ST_IDLE;
    end
  end

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction payload.
  always_ff @(posedge i_ex_gck) begin
    if (slice_last && i_instr_vld) begin
      instr_q <= i_instr;
    end
  end

  // The mask is only live while some bit above the LSB is set. The LSB gives
  // the value of P that the current instruction needs in order to run.
  always_comb skip = |mask_q[`EX_COND_W-1:1] && (i_pred != mask_q[0]);

  always_comb run = state_q == ST_EXEC && !skip;

  // Each instruction consumes one mask bit. An executed conditional
  // instruction replaces the mask with its own.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      mask_q <= '0;
    end else if (state_q == ST_EXEC && slice_last) begin
      if (instr_q.op == OP_COND && !skip) begin
        mask_q <= {instr_q.lhs, instr_q.rhs};
      end else begin
        mask_q <= {1'b0, mask_q[`EX_COND_W-1:1]};
      end
    end
  end

  always_comb begin
    o_ctrl.op  = instr_q.op;
    o_ctrl.lhs = instr_q.lhs;
    o_ctrl.rhs = instr_q.rhs;
    o_ctrl.dst = instr_q.dst;
    o_ctrl.run = run;
  end

  // Done fires for skipped instructions too so the repeat count moves on.
  always_comb o_instr_done = state_q == ST_EXEC && slice_last;

  // Count mode lives in the low lhs bits and the count in rhs.
  always_comb o_cnt_load = run && slice_last && instr_q.op == OP_CNT;
  always_comb o_cnt_mode = count_mode_e'(instr_q.lhs[1:0]);
  always_comb o_cnt_val  = instr_q.rhs;

  // Nothing runs without an issued instruction.
  a_no_run_idle: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    state_q == ST_IDLE |-> !o_ctrl.run
  );

endmodule

// ==== logic/ex_counters.sv ====
`timescale 1ns/100ps

`include "ex_defines.svh"

// Slice counter plus the repeat counter set up by count instructions.
module ex_counters import ex_isa_pkg::*, ex_dp_pkg::*; (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,

  // Count instruction load, qualified by the issue sequencer.
  input  var logic                 i_cnt_load,
  input  var count_mode_e          i_cnt_mode,
  input  var logic [`EX_CNT_W-1:0] i_cnt_val,

  // Strobe on the final slice of every executed or skipped instruction.
  input  var logic                 i_instr_done,

  output var slice_idx_t           o_slice,
  output var logic                 o_chain,
  output var count_mode_e          o_mode
);

  // Index of the final slice of a word.
  localparam slice_idx_t SLICE_LAST = slice_idx_t'(`EX_NUM_SLICES - 1);

  slice_idx_t           slice_q;
  logic [`EX_CNT_W-1:0] count_q;
  count_mode_e          mode_q;
  logic                 first_q;
  logic                 count_dec;

  // The slice counter free-runs from reset and wraps after the last slice.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      slice_q <= '0;
    end else begin
      slice_q <= (slice_q == SLICE_LAST) ? '0 : slice_q + 2'd1;
    end
  end

  // A finished instruction counts down an active repeat unless it is the
  // count instruction itself. Skipped instructions still count.
  always_comb count_dec = i_instr_done && |count_q && !i_cnt_load;

  // Load takes priority over the decrement. The first flag marks the
  // instruction that directly follows a load.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      count_q <= '0;
      mode_q  <= CNT_NONE;
      first_q <= 1'b0;
    end else if (i_cnt_load) begin
      count_q <= i_cnt_val;
      mode_q  <= i_cnt_mode;
      first_q <= 1'b1;
    end else if (i_instr_done) begin
      first_q <= 1'b0;
      if (count_dec) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_comb o_slice = slice_q;

  // Once the count has run out the mode no longer applies.
  always_comb o_mode = |count_q ? mode_q : CNT_NONE;

  // The first instruction of a carry chain starts from its own carry-in,
  // every later one picks up the carry saved by its predecessor.
  always_comb o_chain = mode_q == CNT_CARRY && |count_q && !first_q;

  // A count load only lands at the end of an instruction, and never
  // alongside a decrement of the previous count.
  a_load_no_dec: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    i_cnt_load |-> i_instr_done && !count_dec && slice_q == SLICE_LAST
  );

endmodule

// ==== logic/ex_dp_pkg.sv ====
// Types carried between the datapath and sequencing blocks of the core.
package ex_dp_pkg;

  import ex_isa_pkg::*;

  // One slice of data.
  typedef logic [3:0] slice_t;

  // Position of the current slice within the word, LSB slice first.
  typedef logic [1:0] slice_idx_t;

  // ALU flags. Z covers the whole word; N, C and V come from the top slice.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

  // Control for the datapath, taken from the latched instruction. The run
  // bit is only set while an unskipped instruction is being executed.
  typedef struct packed {
    opcode_e op;
    reg_t    lhs;
    reg_t    rhs;
    reg_t    dst;
    logic    run;
  } alu_ctrl_t;

  // A single slice being written back to the register file.
  typedef struct packed {
    logic       vld;
    reg_t       dst;
    slice_idx_t idx;
    slice_t     data;
  } wb_t;

  // Issue sequencer state.
  typedef enum logic {
    ST_IDLE,
    ST_EXEC
  } issue_state_e;

endpackage

// ==== logic/ex_isa_pkg.sv ====
// Types describing instructions as they arrive at the execution core.
package ex_isa_pkg;

  // Register index. Index zero is hardwired to read as zero.
  typedef logic [3:0] reg_t;

  // Operation encodings. Compares write P rather than a register.
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_CEQ,
    OP_CLT,
    OP_CLTU,
    OP_CNT,
    OP_COND
  } opcode_e;

  // Modes applied to the instructions that follow a count instruction.
  typedef enum logic [1:0] {
    CNT_NONE,
    CNT_CARRY,
    CNT_ANDP,
    CNT_ORP
  } count_mode_e;

  // Instruction word. Count and conditional instructions reuse the operand
  // fields for their mode, count and mask.
  typedef struct packed {
    opcode_e op;
    reg_t    dst;
    reg_t    lhs;
    reg_t    rhs;
  } instr_t;

endpackage

// ==== logic/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Width of an architectural register and of a full data word.
`define EX_DATA_W 16

// Width of one slice processed per clock cycle.
`define EX_SLICE_W 4

// Number of slices that make up one word, and so cycles per instruction.
`define EX_NUM_SLICES 4

// Number of registers in the register file, including the zero register.
`define EX_NUM_REGS 16

// Width of the conditional execution mask.
`define EX_COND_W 8

// Width of the repeat counter loaded by a count instruction.
`define EX_CNT_W 4

`endif
